// File: hdl/sprite_cfg.svh
// Sprite display configuration: VGA timing, tile geometry, entity slots, APB map
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// 640x480 at 60 Hz, one pixel per clk
`define SPR_H_ACTIVE 640   // Visible pixels per line
`define SPR_H_FP     16    // Front porch
`define SPR_H_SYNC   96    // Sync pulse width
`define SPR_H_BP     48    // Back porch
`define SPR_H_TOTAL  (`SPR_H_ACTIVE + `SPR_H_FP + `SPR_H_SYNC + `SPR_H_BP)

`define SPR_V_ACTIVE 480   // Visible lines per frame
`define SPR_V_FP     10    // Front porch lines
`define SPR_V_SYNC   2     // Sync pulse lines
`define SPR_V_BP     33    // Back porch lines
`define SPR_V_TOTAL  (`SPR_V_ACTIVE + `SPR_V_FP + `SPR_V_SYNC + `SPR_V_BP)

// Tile and glyph geometry
`define SPR_TILE_SHIFT 5   // 32-pixel tiles
`define SPR_PIX_SHIFT  2   // Each glyph bit covers 4x4 pixels

`define SPR_NUM_ENT    9   // Entity slots
`define SPR_FLIP_FIRST 7   // Slots from here on are mirrored

`define SPR_ADDR_PAL   8'h24 // Palette byte address, entity n at 4n

`endif

// File: hdl/sprite_pkg.sv
// Sprite display types: entity table, scan position, pixel and palette, glyph ROM
`include "sprite_cfg.svh"

package sprite_pkg;

  typedef struct packed {
    logic [3:0] id;      // Sprite ID, 4'hf marks an unused slot
    logic [1:0] orient;  // Rotation in quarter turns
    logic [7:0] tile;    // Row in [7:4], column in [3:0]
  } entity_t;

  typedef entity_t [`SPR_NUM_ENT-1:0] entity_tab_t;

  typedef struct packed {
    logic [7:0] bg;  // Background colour, upper byte on APB
    logic [7:0] fg;  // Foreground colour, lower byte on APB
  } palette_t;

  typedef struct packed {
    logic [9:0] h;       // Pixel column
    logic [9:0] v;       // Line
    logic       active;  // Inside the visible area
    logic       hsync;   // Active low
    logic       vsync;   // Active low
  } scan_t;

  typedef struct packed {
    logic colour;  // 1 selects fg
    logic active;
    logic hsync;
    logic vsync;
  } pix_t;

  // Indexed [id][row][col], bit index is the column
  localparam logic [0:15][0:7][7:0] SPR_GLYPHS = '{
    '{8'h18, 8'h3c, 8'h7e, 8'hff, 8'h18, 8'h18, 8'h18, 8'h18},  // Arrow
    '{8'h01, 8'h03, 8'h07, 8'h0f, 8'h1f, 8'h3f, 8'h7f, 8'hff},  // Ramp
    '{8'h0f, 8'h0f, 8'h0f, 8'h0f, 8'h00, 8'h00, 8'h00, 8'h00},  // Quadrant
    '{8'h7e, 8'h02, 8'h02, 8'h3e, 8'h02, 8'h02, 8'h02, 8'h00},  // Letter F
    '{8'h81, 8'h42, 8'h24, 8'h18, 8'h18, 8'h24, 8'h42, 8'h81},
    '{8'hff, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'hff},
    '{8'h3c, 8'h42, 8'h81, 8'h81, 8'h81, 8'h81, 8'h42, 8'h3c},
    '{8'h10, 8'h18, 8'h14, 8'h10, 8'h10, 8'h10, 8'h10, 8'h7c},
    '{8'haa, 8'h55, 8'haa, 8'h55, 8'haa, 8'h55, 8'haa, 8'h55},
    '{8'h03, 8'h0c, 8'h30, 8'hc0, 8'h03, 8'h0c, 8'h30, 8'hc0},
    '{8'h00, 8'h66, 8'hff, 8'hff, 8'h7e, 8'h3c, 8'h18, 8'h00},  // Heart
    '{8'h0f, 8'h07, 8'h0b, 8'h11, 8'h20, 8'h40, 8'h80, 8'h00},
    '{8'hff, 8'h00, 8'hff, 8'h00, 8'hff, 8'h00, 8'hff, 8'h00},
    '{8'h3e, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h7f},
    '{8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80},
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}   // Blank
  };

endpackage

// File: hdl/entity_regs.sv
// APB register file holding the nine entity words and the palette
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module entity_regs import sprite_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output entity_tab_t entities,
  output palette_t    palette
);

  localparam int PAL_IDX = `SPR_ADDR_PAL >> 2;  // Word index of the palette

  logic [5:0]  word_idx;  // Word address
  logic        addr_err;  // Unaligned or past the palette
  logic        setup;     // First cycle of a transfer
  logic        wr_en;     // Write commits in the access cycle
  logic [31:0] rd_data;   // Read mux

  assign word_idx = paddr[7:2];
  assign addr_err = (paddr[1:0] != 2'b00) || (paddr > `SPR_ADDR_PAL);
  assign setup    = psel && !penable;
  assign wr_en    = psel && penable && pwrite && !addr_err;
  assign pready   = 1'b1;  // Zero wait states

  always_comb begin
    rd_data = '0;  // Unused upper bits read as zero
    if (word_idx < `SPR_NUM_ENT)
      rd_data[$bits(entity_t)-1:0] = entities[word_idx];
    else if (word_idx == PAL_IDX)
      rd_data[$bits(palette_t)-1:0] = palette;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SPR_NUM_ENT; i++) begin
        entities[i] <= '{id: 4'hf, orient: 2'd0, tile: 8'd0};  // All slots unused
      end
      palette <= '0;
    end else if (wr_en) begin
      if (word_idx < `SPR_NUM_ENT)
        entities[word_idx] <= pwdata[$bits(entity_t)-1:0];
      else
        palette <= pwdata[$bits(palette_t)-1:0];  // Only PAL_IDX passes the decode
    end
  end

  // Read data and error are captured in setup and held for the access cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      prdata  <= (setup && !pwrite && !addr_err) ? rd_data : '0;
      pslverr <= setup && addr_err;
    end
  end

  // Access phase only ever follows a setup phase of the same transfer
  a_apb_phase: assert property (@(posedge clk) disable iff (rst)
    penable |-> psel && $past(psel));

endmodule

// File: hdl/vga_timing.sv
// VGA 640x480 timing generator producing the registered scan position and syncs
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module vga_timing import sprite_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output scan_t scan
);

  localparam int HS_START = `SPR_H_ACTIVE + `SPR_H_FP;  // First sync clock
  localparam int HS_END   = HS_START + `SPR_H_SYNC;     // First clock after sync
  localparam int VS_START = `SPR_V_ACTIVE + `SPR_V_FP;
  localparam int VS_END   = VS_START + `SPR_V_SYNC;

  logic [9:0] h_cnt;    // Pixel counter
  logic [9:0] v_cnt;    // Line counter
  logic       h_wrap;   // Last clock of a line
  logic       v_wrap;   // Last line of a frame
  logic       active_d; // Decoded from the counters
  logic       hsync_d;
  logic       vsync_d;

  assign h_wrap = (h_cnt == 10'(`SPR_H_TOTAL - 1));
  assign v_wrap = (v_cnt == 10'(`SPR_V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_wrap) begin
        h_cnt <= '0;
        v_cnt <= v_wrap ? 10'd0 : v_cnt + 10'd1;  // Line advance at line end
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  // Blanking order per line is active, front porch, sync, back porch
  assign active_d = (h_cnt < `SPR_H_ACTIVE) && (v_cnt < `SPR_V_ACTIVE);
  assign hsync_d  = !((h_cnt >= HS_START) && (h_cnt < HS_END));  // Active low
  assign vsync_d  = !((v_cnt >= VS_START) && (v_cnt < VS_END));

  always_ff @(posedge clk) begin
    if (rst) begin
      scan <= '{h: 10'd0, v: 10'd0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
    end else begin
      scan.h      <= h_cnt;  // One cycle behind the counters
      scan.v      <= v_cnt;
      scan.active <= active_d;
      scan.hsync  <= hsync_d;
      scan.vsync  <= vsync_d;
    end
  end

  // h=0 reaches the pins SPR_H_BP clocks after hsync goes high again

  // Counter stays inside the line
  a_h_range: assert property (@(posedge clk) disable iff (rst)
    h_cnt < 10'(`SPR_H_TOTAL));

endmodule

// File: hdl/sprite_compositor.sv
// Per-pixel entity hit test with priority, rotation, mirroring and glyph lookup
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_compositor import sprite_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  scan_t       scan,
  input  entity_tab_t entities,
  output pix_t        pix
);

  logic [9:0]              tile_col;  // Tile column of this pixel
  logic [9:0]              tile_row;  // Tile row of this pixel
  logic [2:0]              r;         // Glyph row inside the tile
  logic [2:0]              c;         // Glyph column inside the tile
  logic [`SPR_NUM_ENT-1:0] hit;       // Slots covering this tile
  logic [`SPR_NUM_ENT-1:0] win;       // One-hot priority winner
  logic                    found;
  entity_t                 sel_ent;   // Winning entity
  logic                    sel_flip;  // Winner sits in a mirrored slot
  logic [2:0]              c_eff;     // Column after mirroring
  logic [2:0]              g_row;     // Glyph ROM row
  logic [2:0]              g_col;     // Glyph ROM column
  logic                    g_bit;

  assign tile_col = scan.h >> `SPR_TILE_SHIFT;
  assign tile_row = scan.v >> `SPR_TILE_SHIFT;
  assign c        = scan.h[`SPR_TILE_SHIFT-1:`SPR_PIX_SHIFT];  // 4 pixels per glyph bit
  assign r        = scan.v[`SPR_TILE_SHIFT-1:`SPR_PIX_SHIFT];

  always_comb begin
    for (int i = 0; i < `SPR_NUM_ENT; i++) begin
      hit[i] = (entities[i].id != 4'hf) &&
               (tile_row == {6'd0, entities[i].tile[7:4]}) &&
               (tile_col == {6'd0, entities[i].tile[3:0]});
    end
  end

  // Lowest slot index wins
  always_comb begin
    found    = 1'b0;
    win      = '0;
    sel_ent  = entities[0];
    sel_flip = 1'b0;
    for (int i = 0; i < `SPR_NUM_ENT; i++) begin
      if (hit[i] && !found) begin
        found    = 1'b1;
        win[i]   = 1'b1;
        sel_ent  = entities[i];
        sel_flip = (i >= `SPR_FLIP_FIRST);
      end
    end
  end

  assign c_eff = sel_flip ? ~c : c;  // 7-c on three bits

  always_comb begin
    case (sel_ent.orient)
      2'd0: begin
        g_row = r;
        g_col = c_eff;
      end
      2'd1: begin  // Quarter turn
        g_row = ~c_eff;
        g_col = r;
      end
      2'd2: begin  // Half turn
        g_row = ~r;
        g_col = ~c_eff;
      end
      default: begin
        g_row = c_eff;
        g_col = ~r;
      end
    endcase
  end

  assign g_bit = SPR_GLYPHS[sel_ent.id][g_row][g_col];

  always_ff @(posedge clk) begin
    if (rst) begin
      pix <= '{colour: 1'b0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
    end else begin
      pix.colour <= found && scan.active && g_bit;  // Off in blanking and empty tiles
      pix.active <= scan.active;
      pix.hsync  <= scan.hsync;  // Syncs ride along with the pixel
      pix.vsync  <= scan.vsync;
    end
  end

  // Winner is the lowest set bit of the hit vector, at most one slot
  a_one_winner: assert property (@(posedge clk) disable iff (rst)
    (win == (hit & -hit)) && (found == (hit != '0)));

endmodule

// File: hdl/pixel_output.sv
// Output stage applying the palette and blanking with syncs kept in step
`timescale 1ns/1ps

module pixel_output import sprite_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  pix_t       pix,
  input  palette_t   palette,
  output logic [7:0] rgb,
  output logic       hsync,
  output logic       vsync
);

  logic [7:0] colour_d;  // Palette pick before blanking

  assign colour_d = pix.colour ? palette.fg : palette.bg;

  always_ff @(posedge clk) begin
    if (rst) begin
      rgb   <= 8'd0;
      hsync <= 1'b1;  // Inactive
      vsync <= 1'b1;
    end else begin
      rgb   <= pix.active ? colour_d : 8'd0;  // Black in blanking
      hsync <= pix.hsync;
      vsync <= pix.vsync;
    end
  end

  // Sync pulses sit inside blanking, so the port is black during them
  a_blank_black: assert property (@(posedge clk) disable iff (rst)
    (!hsync || !vsync) |-> rgb == 8'd0);

endmodule

// File: hdl/sprite_display_top.sv
// Sprite display top: APB registers, VGA timing, compositor and output stage
`timescale 1ns/1ps

module sprite_display_top import sprite_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic [7:0]  rgb,
  output logic        hsync,
  output logic        vsync
);

  entity_tab_t entities;  // Entity table to the compositor
  palette_t    palette;   // Colours to the output stage
  scan_t       scan;      // Scan position and raw syncs
  pix_t        pix;       // Pixel colour bit with syncs

  entity_regs entity_regs_inst (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .entities (entities),
    .palette  (palette)
  );

  vga_timing vga_timing_inst (
    .clk  (clk),
    .rst  (rst),
    .scan (scan)
  );

  sprite_compositor sprite_compositor_inst (
    .clk      (clk),
    .rst      (rst),
    .scan     (scan),
    .entities (entities),
    .pix      (pix)
  );

  pixel_output pixel_output_inst (
    .clk     (clk),
    .rst     (rst),
    .pix     (pix),
    .palette (palette),
    .rgb     (rgb),
    .hsync   (hsync),
    .vsync   (vsync)
  );

endmodule

// File: sim/tb_sprite_display.sv
// Sprite display testbench: APB registers, sync timing and table-driven frame probes
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module tb_sprite_display import sprite_pkg::*; ();

  localparam int NUM_TESTS  = 8;
  localparam int MAX_PROBES = 16;
  localparam int FRAME_CLKS = `SPR_H_TOTAL * `SPR_V_TOTAL;
  localparam int EDGE_OFS   = `SPR_V_TOTAL - `SPR_V_ACTIVE - `SPR_V_FP;  // Hsync rises before line 0
  localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 3) * FRAME_CLKS * 8;
  localparam int MIRROR_TEST = 4;

  logic        clk = 1'b0;
  logic        rst;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready, pslverr;
  logic [7:0]  rgb;
  logic        hsync, vsync;

  string       test_name [NUM_TESTS];
  entity_tab_t test_ents [NUM_TESTS];
  palette_t    test_pal  [NUM_TESTS];
  int          probe_cnt [NUM_TESTS];
  int          probe_h   [NUM_TESTS][MAX_PROBES];
  int          probe_v   [NUM_TESTS][MAX_PROBES];
  logic [7:0]  probe_exp [NUM_TESTS][MAX_PROBES];

  sprite_display_top sprite_display_top_inst (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .rgb(rgb), .hsync(hsync), .vsync(vsync)
  );

  always #4 clk = ~clk;  // 8 ns pixel clock

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the display never produced a frame in the allowed time");
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rgb(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      stop_run($sformatf("** Error %s: expected rgb %h, actual %h", name, exp, act));
  endtask

  task automatic check_prdata(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp)
      stop_run($sformatf("** Error %s: expected prdata %h, actual %h", name, exp, act));
  endtask

  task automatic check_entity(input string name, input entity_t exp, input entity_t act);
    if (act !== exp)
      stop_run($sformatf("** Error %s: expected entity %h, actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
      stop_run($sformatf("** Error %s: expected %0d clocks, actual %0d", name, exp, act));
  endtask

  // Compositor rule applied to the glyph ROM
  function automatic logic [7:0] ref_rgb(entity_tab_t tab, palette_t pal, int h, int v);
    int   r, c, cc, gr, gc;
    logic hit_any, bit_on;
    if (h >= `SPR_H_ACTIVE || v >= `SPR_V_ACTIVE) return 8'd0;
    r = (v >> `SPR_PIX_SHIFT) % 8;
    c = (h >> `SPR_PIX_SHIFT) % 8;
    hit_any = 1'b0;
    bit_on  = 1'b0;
    for (int i = 0; i < `SPR_NUM_ENT; i++) begin
      if (!hit_any && tab[i].id != 4'hf && int'(tab[i].tile[7:4]) == (v >> `SPR_TILE_SHIFT)
          && int'(tab[i].tile[3:0]) == (h >> `SPR_TILE_SHIFT)) begin
        hit_any = 1'b1;
        cc = (i >= `SPR_FLIP_FIRST) ? 7 - c : c;  // Mirrored slots
        case (tab[i].orient)
          2'd0: begin
            gr = r;
            gc = cc;
          end
          2'd1: begin
            gr = 7 - cc;
            gc = r;
          end
          2'd2: begin
            gr = 7 - r;
            gc = 7 - cc;
          end
          default: begin
            gr = cc;
            gc = 7 - r;
          end
        endcase
        bit_on = SPR_GLYPHS[tab[i].id][gr][gc];
      end
    end
    return bit_on ? pal.fg : pal.bg;
  endfunction

  task automatic add_probe_exp(input int t, input int h, input int v, input logic [7:0] exp);
    probe_h[t][probe_cnt[t]]   = h;
    probe_v[t][probe_cnt[t]]   = v;
    probe_exp[t][probe_cnt[t]] = exp;
    probe_cnt[t]++;
  endtask

  task automatic add_probe(input int t, input int h, input int v);
    add_probe_exp(t, h, v, ref_rgb(test_ents[t], test_pal[t], h, v));
  endtask

  // Random pixels on rising lines of one tile
  task automatic add_tile_probes(input int t, input int row, input int col, input int n);
    int step;
    step = 32 / n;
    for (int k = 0; k < n; k++)
      add_probe(t, col * 32 + int'($urandom % 32), row * 32 + k * step + int'($urandom % step));
  endtask

  task automatic new_test(input int t, input string name);
    test_name[t] = name;
    probe_cnt[t] = 0;
    for (int i = 0; i < `SPR_NUM_ENT; i++)
      test_ents[t][i] = entity_t'{id: 4'hf, orient: 2'd0, tile: 8'd0};
    test_pal[t].fg = 8'($urandom % 254 + 1);  // Neither colour is black
    test_pal[t].bg = ~test_pal[t].fg;  // Always distinct colours
  endtask

  task automatic build_tests();
    int row, col, x, v;
    for (int o = 0; o < 4; o++) begin
      new_test(o, $sformatf("orient_%0d", o));
      row = int'($urandom % 14);
      col = int'($urandom % 16);
      test_ents[o][0] = entity_t'{id: 4'd3, orient: 2'(o), tile: {4'(row), 4'(col)}};
      add_tile_probes(o, row, col, 6);
    end
    new_test(MIRROR_TEST, "mirror");
    test_ents[4][0] = entity_t'{id: 4'd3, orient: 2'd0, tile: 8'h22};
    test_ents[4][7] = entity_t'{id: 4'd3, orient: 2'd0, tile: 8'h25};
    test_ents[4][8] = entity_t'{id: 4'd11, orient: 2'd2, tile: 8'h79};
    for (int k = 0; k < 6; k++) begin
      v = 64 + k * 5 + int'($urandom % 5);
      x = int'($urandom % 32);
      add_probe(4, 64 + x, v);         // Slot 0 tile
      // Slot 7 tile shows the slot 0 pixel from the opposite column
      add_probe_exp(4, 160 + 31 - x, v, ref_rgb(test_ents[4], test_pal[4], 64 + x, v));
    end
    add_tile_probes(4, 7, 9, 4);
    new_test(5, "overlap");
    test_ents[5][1] = entity_t'{id: 4'd0, orient: 2'd0, tile: 8'h34};
    test_ents[5][4] = entity_t'{id: 4'd6, orient: 2'd1, tile: 8'h34};
    add_tile_probes(5, 3, 4, 8);
    new_test(6, "reveal");
    test_ents[6]    = test_ents[5];
    test_ents[6][1] = entity_t'{id: 4'hf, orient: 2'd0, tile: 8'h34};
    add_tile_probes(6, 3, 4, 8);
    new_test(7, "blank_bg");
    test_ents[7][2] = entity_t'{id: 4'd10, orient: 2'd0, tile: 8'h11};
    add_tile_probes(7, 1, 1, 4);
    add_probe(7, 650, 100);  // Horizontal blanking
    add_probe(7, 300, 300);  // Empty tile gives bg
    add_probe(7, 690, 400);
    add_probe(7, 100, 485);  // Vertical blanking
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);  // Access cycle
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) stop_run("pready was low in an APB access cycle");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic test_registers();
    logic [31:0] rd, w;
    logic        err;
    entity_t     e0;
    for (int i = 0; i < `SPR_NUM_ENT; i++) begin
      apb_xfer(1'b0, 8'(4 * i), 32'd0, rd, err);
      check_entity("reset_entity", entity_t'{id: 4'hf, orient: 2'd0, tile: 8'd0}, rd[13:0]);
      check_prdata("reset_entity_word", 32'h0000_3c00, rd);
    end
    apb_xfer(1'b0, `SPR_ADDR_PAL, 32'd0, rd, err);
    check_prdata("reset_palette", 32'd0, rd);
    for (int i = 0; i < `SPR_NUM_ENT; i++) begin
      w = $urandom;
      apb_xfer(1'b1, 8'(4 * i), w, rd, err);
      if (err) stop_run("pslverr rose on a write to a valid entity address");
      apb_xfer(1'b0, 8'(4 * i), 32'd0, rd, err);
      check_entity("entity_readback", w[13:0], rd[13:0]);
      check_prdata("entity_word_readback", {18'd0, w[13:0]}, rd);
    end
    w = $urandom;
    apb_xfer(1'b1, `SPR_ADDR_PAL, w, rd, err);
    apb_xfer(1'b0, `SPR_ADDR_PAL, 32'd0, rd, err);
    check_prdata("palette_readback", {16'd0, w[15:0]}, rd);
    apb_xfer(1'b0, 8'h00, 32'd0, rd, err);
    e0 = rd[13:0];
    apb_xfer(1'b1, 8'h28, $urandom, rd, err);
    if (!err) stop_run("pslverr stayed low on a write past the palette");
    apb_xfer(1'b1, 8'h01, $urandom, rd, err);
    if (!err) stop_run("pslverr stayed low on an unaligned write");
    apb_xfer(1'b0, 8'h00, 32'd0, rd, err);
    check_entity("entity_after_error", e0, rd[13:0]);
    apb_xfer(1'b0, `SPR_ADDR_PAL, 32'd0, rd, err);
    check_prdata("palette_after_error", {16'd0, w[15:0]}, rd);
  endtask

  function automatic logic sync_of(input int which);
    return (which == 0) ? hsync : vsync;
  endfunction

  // Low width and fall-to-fall period of one sync, counted at negedges
  task automatic measure_sync(input int which, output int low, output int period);
    logic prev;
    prev = sync_of(which);
    forever begin
      @(negedge clk);
      if (prev && !sync_of(which)) break;
      prev = sync_of(which);
    end
    low    = 0;
    period = 0;
    while (!sync_of(which)) begin
      @(negedge clk);
      low++;
    end
    period = low;
    while (sync_of(which)) begin
      @(negedge clk);
      period++;
    end
  endtask

  task automatic check_syncs();
    int low, period;
    measure_sync(0, low, period);
    check_count("hsync_width", `SPR_H_SYNC, low);
    check_count("hsync_period", `SPR_H_TOTAL, period);
    measure_sync(1, low, period);
    check_count("vsync_width", `SPR_V_SYNC * `SPR_H_TOTAL, low);
    check_count("vsync_period", FRAME_CLKS, period);
  endtask

  task automatic load_test(input int t);
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i < `SPR_NUM_ENT; i++)
      apb_xfer(1'b1, 8'(4 * i), {18'd0, test_ents[t][i]}, rd, err);
    apb_xfer(1'b1, `SPR_ADDR_PAL, {16'd0, test_pal[t]}, rd, err);
  endtask

  // Probes are ordered by line, line v starts SPR_H_BP clocks after hsync rise v+EDGE_OFS
  task automatic scan_frame(input int t);
    logic prev;
    int   edges, target, cur_h, wait_n;
    prev = vsync;
    forever begin
      @(negedge clk);
      if (prev && !vsync) break;
      prev = vsync;
    end
    edges = 0;
    cur_h = 0;
    prev  = hsync;
    for (int p = 0; p < probe_cnt[t]; p++) begin
      target = probe_v[t][p] + EDGE_OFS;
      if (target > edges) begin
        while (edges < target) begin
          @(negedge clk);
          if (!prev && hsync) edges++;
          prev = hsync;
        end
        wait_n = `SPR_H_BP + probe_h[t][p];
      end else begin
        wait_n = probe_h[t][p] - cur_h;  // Same line, further right
      end
      if (wait_n > 0) begin
        repeat (wait_n) @(posedge clk);
        @(negedge clk);
      end
      cur_h = probe_h[t][p];
      prev  = hsync;
      check_rgb($sformatf("%s probe (%0d,%0d)", test_name[t], probe_h[t][p], probe_v[t][p]),
                probe_exp[t][p], rgb);
    end
  endtask

  initial begin
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'd0;
    pwdata  = 32'd0;
    void'($urandom(32'hc9b3_1de6));
    build_tests();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    test_registers();
    check_syncs();
    for (int t = 0; t < NUM_TESTS; t++) begin
      load_test(t);
      scan_frame(t);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/sprite_pkg.sv
hdl/entity_regs.sv
hdl/vga_timing.sv
hdl/sprite_compositor.sv
hdl/pixel_output.sv
hdl/sprite_display_top.sv
sim/tb_sprite_display.sv

// File: Makefile
SIM := obj_dir/Vtb_sprite_display

all: run

$(SIM): verilog.f hdl/sprite_cfg.svh $(shell grep -v '^+' verilog.f)
	verilator --binary --assert -Wno-fatal -f verilog.f \
	  --top-module tb_sprite_display -o Vtb_sprite_display

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
